//--- Makefile
TOP = tb_cache

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f cache.f --top-module $(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx 'STATUS: PASS'

lint:
	verilator --lint-only -Wall --timing -f cache.f --top-module $(TOP)

clean:
	rm -rf obj_dir

//--- cache.f
src/cache_geom_pkg.sv
src/cache_ctrl_pkg.sv
src/way_if.sv
src/way_store.sv
src/lru_tracker.sv
src/cache_ctrl.sv
src/cache.sv
test/tb_cache.sv

//--- src/cache.sv
// two-way set-associative write-back cache top level with CPU and memory ports
`timescale 1ns/1ps

module cache (
    input  logic                  clk,
    input  logic                  rstn,
    input  cache_geom_pkg::word_t addr,
    input  logic                  r_req,
    input  logic                  w_req,
    input  cache_geom_pkg::word_t w_data,
    output cache_geom_pkg::word_t r_data,
    output logic                  miss,
    output logic                  mem_r,
    output logic                  mem_w,
    output cache_geom_pkg::word_t mem_addr,
    output cache_geom_pkg::line_t mem_w_data,
    input  cache_geom_pkg::line_t mem_r_data,
    input  logic                  mem_ready
);
    import cache_geom_pkg::*;

    way_if  ways_bus ();

    index_t lru_index;
    logic   touch;
    logic   touch_way;
    logic   lru_way;

    way_store way_store_i (
        .clk  (clk),
        .rstn (rstn),
        .ways (ways_bus)
    );

    lru_tracker lru_tracker_i (
        .clk       (clk),
        .rstn      (rstn),
        .index     (lru_index),
        .touch     (touch),
        .touch_way (touch_way),
        .lru_way   (lru_way)
    );

    cache_ctrl cache_ctrl_i (
        .clk        (clk),
        .rstn       (rstn),
        .addr       (addr),
        .r_req      (r_req),
        .w_req      (w_req),
        .w_data     (w_data),
        .r_data     (r_data),
        .miss       (miss),
        .mem_r      (mem_r),
        .mem_w      (mem_w),
        .mem_addr   (mem_addr),
        .mem_w_data (mem_w_data),
        .mem_r_data (mem_r_data),
        .mem_ready  (mem_ready),
        .ways       (ways_bus),
        .lru_index  (lru_index),
        .touch      (touch),
        .touch_way  (touch_way),
        .lru_way    (lru_way)
    );

endmodule

//--- src/cache_ctrl.sv
// cache controller with the FSM, request and return buffers, line merge and memory side
`timescale 1ns/1ps

module cache_ctrl (
    input  logic                   clk,
    input  logic                   rstn,
    input  cache_geom_pkg::word_t  addr,
    input  logic                   r_req,
    input  logic                   w_req,
    input  cache_geom_pkg::word_t  w_data,
    output cache_geom_pkg::word_t  r_data,
    output logic                   miss,
    output logic                   mem_r,
    output logic                   mem_w,
    output cache_geom_pkg::word_t  mem_addr,
    output cache_geom_pkg::line_t  mem_w_data,
    input  cache_geom_pkg::line_t  mem_r_data,
    input  logic                   mem_ready,
    way_if.ctrl                    ways,
    output cache_geom_pkg::index_t lru_index,
    output logic                   touch,
    output logic                   touch_way,
    input  logic                   lru_way
);
    import cache_geom_pkg::*;
    import cache_ctrl_pkg::*;

    cache_state_e state_q;
    cache_state_e state_d;
    cache_state_e req_state;
    logic         refill_q;       // fetched line waiting in ret_q

    // request and return buffers
    word_t        addr_q;
    word_t        w_data_q;
    logic         op_q;           // high for a write
    line_t        ret_q;

    // victim buffers for the eviction
    logic         victim_q;
    word_t        victim_addr_q;
    line_t        victim_line_q;

    tag_t         req_tag;
    index_t       req_index;
    word_off_t    req_off;
    logic         lookup;
    logic         any_hit;
    logic         hit_way;
    logic         refill;
    logic         accept;
    logic         victim_way;
    logic         victim_dirty;
    word_t        victim_addr;
    line_t        victim_line;
    word_t        line_addr;
    line_t        word_mask;
    line_t        merge_base;
    line_t        merged_line;
    word_t        hit_word;
    word_t        ret_word;

    assign req_tag   = addr_q[ADDR_W-1 -: TAG_W];
    assign req_index = addr_q[BYTE_OFF_W+WORD_OFF_W +: INDEX_W];
    assign req_off   = addr_q[BYTE_OFF_W +: WORD_OFF_W];
    assign line_addr = {req_tag, req_index, {(BYTE_OFF_W+WORD_OFF_W){1'b0}}};

    assign lookup  = (state_q == s_read) || (state_q == s_write);
    assign any_hit = |ways.hit;
    assign hit_way = ways.hit[1];  // two ways, so way 1 hit or else way 0
    assign refill  = (state_q == s_idle) && refill_q;
    assign accept  = ((state_q == s_idle) && !refill_q) || (lookup && any_hit);

    assign req_state = r_req ? s_read : (w_req ? s_write : s_idle);

    // empty way first, lowest index wins, then the LRU way
    always_comb begin
        if (!ways.rvalid[0]) begin
            victim_way = 1'b0;
        end else if (!ways.rvalid[1]) begin
            victim_way = 1'b1;
        end else begin
            victim_way = lru_way;
        end
    end

    assign victim_dirty = ways.rvalid[victim_way] && ways.rdirty[victim_way];
    assign victim_line  = ways.rline[victim_way];
    assign victim_addr  = {ways.rtag[victim_way], req_index,
                           {(BYTE_OFF_W+WORD_OFF_W){1'b0}}};

    // write word merged into the hit line or the fetched line
    assign word_mask   = line_t'({WORD_W{1'b1}}) << (req_off * WORD_W);
    assign merge_base  = refill_q ? ret_q : ways.rline[hit_way];
    assign merged_line = (merge_base & ~word_mask) | (line_t'(w_data_q) << (req_off * WORD_W));

    assign hit_word = ways.rline[hit_way][req_off*WORD_W +: WORD_W];
    assign ret_word = ret_q[req_off*WORD_W +: WORD_W];
    assign r_data   = refill_q ? ret_word : hit_word;

    // array access
    always_comb begin
        ways.raddr  = addr[BYTE_OFF_W+WORD_OFF_W +: INDEX_W];  // raw address for next lookup
        ways.waddr  = req_index;
        ways.wtag   = req_tag;
        ways.wline  = merged_line;
        ways.we     = '0;
        ways.wvalid = '0;
        ways.wdirty = '0;
        if ((state_q == s_write) && any_hit) begin
            ways.we     = ways.hit;
            ways.wvalid = '1;
            ways.wdirty = '1;
        end else if (refill) begin
            ways.we     = way_vec_t'(1'b1) << victim_q;
            ways.wvalid = '1;
            ways.wdirty = {WAY_NUM{op_q}};  // write allocate leaves the line dirty
            if (!op_q) begin
                ways.wline = ret_q;
            end
        end
    end

    assign lru_index = req_index;
    assign touch     = (lookup && any_hit) || refill;
    assign touch_way = refill_q ? victim_q : hit_way;

    // memory side
    assign miss  = (lookup && !any_hit) || (state_q == s_fetch) || (state_q == s_evict);
    assign mem_r = (state_q == s_fetch);
    assign mem_w = (lookup && !any_hit && victim_dirty) || (state_q == s_evict);

    always_comb begin
        case (state_q)
            s_evict: mem_addr = victim_addr_q;
            s_fetch: mem_addr = line_addr;
            default: mem_addr = victim_addr;  // write-back starts in the lookup cycle
        endcase
    end

    assign mem_w_data = (state_q == s_evict) ? victim_line_q : victim_line;

    always_comb begin
        state_d = state_q;
        case (state_q)
            s_idle: begin
                if (!refill_q) begin
                    state_d = req_state;
                end
            end
            s_read, s_write: begin
                if (any_hit) begin
                    state_d = req_state;  // back-to-back request on a hit
                end else if (victim_dirty) begin
                    state_d = s_evict;
                end else begin
                    state_d = s_fetch;
                end
            end
            s_evict: begin
                if (mem_ready) begin
                    state_d = s_fetch;
                end
            end
            s_fetch: begin
                if (mem_ready) begin
                    state_d = s_idle;
                end
            end
            default: state_d = s_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state_q  <= s_idle;
            refill_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if ((state_q == s_fetch) && mem_ready) begin
                refill_q <= 1'b1;
            end else if (refill) begin
                refill_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q   <= addr;
            w_data_q <= w_data;
            op_q     <= w_req && !r_req;
        end
        if (lookup && !any_hit) begin
            victim_q      <= victim_way;
            victim_addr_q <= victim_addr;
            victim_line_q <= victim_line;
        end
        if ((state_q == s_fetch) && mem_ready) begin
            ret_q <= mem_r_data;
        end
    end

    // strobes stay put while memory withholds ready
    a_mem_hold: assert property (@(posedge clk) disable iff (!rstn)
        ((mem_r || mem_w) && !mem_ready) |=> $stable({mem_r, mem_w}))
        else $error("memory strobe changed before mem_ready");

    // miss must cover the whole memory wait up to the refill
    a_miss_wait: assert property (@(posedge clk) disable iff (!rstn)
        (state_q inside {s_fetch, s_evict}) |=> (miss || refill))
        else $error("miss dropped before the refill cycle");

endmodule

//--- src/cache_ctrl_pkg.sv
// cache controller package holding the FSM state encoding
package cache_ctrl_pkg;

    typedef enum logic [2:0] {
        s_idle,   // take a new request or finish a refill
        s_read,   // read lookup
        s_write,  // write lookup
        s_fetch,  // line requested from memory
        s_evict   // dirty victim going out to memory
    } cache_state_e;

endpackage

//--- src/cache_geom_pkg.sv
// cache geometry package with address split, line layout and shared data types
package cache_geom_pkg;

    localparam int ADDR_W     = 32;  // byte address
    localparam int WORD_W     = 32;
    localparam int BYTE_OFF_W = 2;   // word aligned accesses only
    localparam int WORD_OFF_W = 2;   // 4 words per line
    localparam int INDEX_W    = 3;   // 8 sets
    localparam int WAY_NUM    = 2;   // two-way set associative

    localparam int SET_NUM = 1 << INDEX_W;
    localparam int LINE_W  = WORD_W << WORD_OFF_W;                        // 128 bits
    localparam int TAG_W   = ADDR_W - INDEX_W - WORD_OFF_W - BYTE_OFF_W;  // 25 bits

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [LINE_W-1:0]     line_t;
    typedef logic [TAG_W-1:0]      tag_t;
    typedef logic [INDEX_W-1:0]    index_t;
    typedef logic [WORD_OFF_W-1:0] word_off_t;
    typedef logic [WAY_NUM-1:0]    way_vec_t;  // one bit per way

endpackage

//--- src/lru_tracker.sv
// replacement history with one most-recently-used bit per set, giving the LRU way
`timescale 1ns/1ps

module lru_tracker (
    input  logic                   clk,
    input  logic                   rstn,
    input  cache_geom_pkg::index_t index,
    input  logic                   touch,
    input  logic                   touch_way,
    output logic                   lru_way
);
    import cache_geom_pkg::*;

    // exact LRU for two ways needs a single bit per set
    logic [SET_NUM-1:0] mru_q;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            mru_q <= '0;
        end else if (touch) begin
            mru_q[index] <= touch_way;  // hit or refill way becomes MRU
        end
    end

    assign lru_way = ~mru_q[index];  // the other way

endmodule

//--- src/way_if.sv
// array access bundle between the cache controller and the way storage
`timescale 1ns/1ps

interface way_if;
    import cache_geom_pkg::*;

    // controller side
    index_t   raddr;  // read index from raw cpu address
    index_t   waddr;  // write index from buffered address
    tag_t     wtag;   // buffered tag, also the hit compare value
    way_vec_t wvalid;
    way_vec_t wdirty;
    line_t    wline;
    way_vec_t we;     // per way write enable

    // storage side
    way_vec_t rvalid;
    way_vec_t rdirty;
    tag_t     rtag  [WAY_NUM];
    line_t    rline [WAY_NUM];
    way_vec_t hit;

    modport ctrl (
        output raddr, waddr, wtag, wvalid, wdirty, wline, we,
        input  rvalid, rdirty, rtag, rline, hit
    );

    modport store (
        input  raddr, waddr, wtag, wvalid, wdirty, wline, we,
        output rvalid, rdirty, rtag, rline, hit
    );

endinterface

//--- src/way_store.sv
// way storage with valid, dirty, tag and data arrays for both ways and hit detection
`timescale 1ns/1ps

module way_store (
    input logic clk,
    input logic rstn,
    way_if.store ways
);
    import cache_geom_pkg::*;

    way_vec_t valid_q [SET_NUM];  // per set, one bit per way
    way_vec_t dirty_q [SET_NUM];
    tag_t     tag_mem  [WAY_NUM][SET_NUM];
    line_t    line_mem [WAY_NUM][SET_NUM];

    // state bits, cleared so every line starts invalid
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int s = 0; s < SET_NUM; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
            ways.rvalid <= '0;
            ways.rdirty <= '0;
        end else begin
            for (int w = 0; w < WAY_NUM; w++) begin
                if (ways.we[w]) begin
                    valid_q[ways.waddr][w] <= ways.wvalid[w];
                    dirty_q[ways.waddr][w] <= ways.wdirty[w];
                end
            end
            ways.rvalid <= valid_q[ways.raddr];  // old value on same-cycle write
            ways.rdirty <= dirty_q[ways.raddr];
        end
    end

    // tag and data arrays, synchronous read
    always_ff @(posedge clk) begin
        for (int w = 0; w < WAY_NUM; w++) begin
            if (ways.we[w]) begin
                tag_mem[w][ways.waddr]  <= ways.wtag;
                line_mem[w][ways.waddr] <= ways.wline;
            end
            ways.rtag[w]  <= tag_mem[w][ways.raddr];
            ways.rline[w] <= line_mem[w][ways.raddr];
        end
    end

    // registered read tag against the buffered request tag
    always_comb begin
        for (int w = 0; w < WAY_NUM; w++) begin
            ways.hit[w] = ways.rvalid[w] && (ways.rtag[w] == ways.wtag);
        end
    end

    // a tag is only ever allocated into one way of a set
    a_single_hit: assert property (@(posedge clk) disable iff (!rstn)
        $onehot0(ways.hit))
        else $error("tag hit in more than one way");

endmodule

//--- test/tb_cache.sv
// testbench for the two-way write-back cache with memory model, reference model and checks
`timescale 1ns/1ps

module tb_cache;
    import cache_geom_pkg::*;

    localparam logic [31:0] SEED = 32'h4c2d5392;
    localparam int RAND_REQS  = 300;
    localparam int N_REQS     = 11 + RAND_REQS;  // directed plus random
    localparam int MAX_CYCLES = N_REQS * 20 + 100;

    logic  clk;
    logic  rstn;
    word_t addr;
    logic  r_req;
    logic  w_req;
    word_t w_data;
    word_t r_data;
    logic  miss;
    logic  mem_r;
    logic  mem_w;
    word_t mem_addr;
    line_t mem_w_data;
    line_t mem_r_data;
    logic  mem_ready;

    int errors;
    int n_done;

    line_t       mem_lines [word_t];  // backing store by line address
    logic [31:0] mem_rng;
    int          mem_wait;
    int          mem_delay;

    word_t       shadow [word_t];     // every cpu write, by word address
    logic        m_valid [8][2];
    logic        m_dirty [8][2];
    tag_t        m_tag   [8][2];
    logic        m_mru   [8];
    logic [31:0] stim_rng;

    // request in flight
    logic  busy;
    logic  in_lookup;
    logic  is_write;
    logic  wb_seen;
    logic  fetch_seen;
    logic  last_hit;
    logic  exp_hit;
    logic  exp_wb;
    word_t exp_wb_addr;
    word_t exp_line_addr;
    word_t exp_data;
    word_t last_wb_addr;

    cache cache_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic word_t pattern(input word_t a);
        return a ^ 32'hA5A5A5A5;  // contents of never written memory
    endfunction

    function automatic word_t ref_word(input word_t a);
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        return pattern(a);
    endfunction

    function automatic line_t ref_line(input word_t line_addr);
        line_t l;
        for (int i = 0; i < 4; i++) begin
            l[i*32 +: 32] = ref_word(line_addr + word_t'(4 * i));  // word 0 in low bits
        end
        return l;
    endfunction

    function automatic line_t mem_line(input word_t line_addr);
        line_t l;
        if (mem_lines.exists(line_addr)) begin
            return mem_lines[line_addr];
        end
        for (int i = 0; i < 4; i++) begin
            l[i*32 +: 32] = pattern(line_addr + word_t'(4 * i));
        end
        return l;
    endfunction

    // LRU and dirty rules per set, returns hit and the predicted write-back
    function automatic logic predict_access(input word_t a, input logic wr,
                                            output logic wb, output word_t wb_addr);
        int   idx;
        int   hw;
        int   v;
        tag_t tag;
        idx     = a[6:4];
        tag     = a[31:7];
        hw      = -1;
        wb      = 1'b0;
        wb_addr = '0;
        for (int w = 0; w < 2; w++) begin
            if (hw < 0 && m_valid[idx][w] && m_tag[idx][w] == tag) begin
                hw = w;
            end
        end
        if (hw >= 0) begin
            m_mru[idx] = (hw == 1);
            if (wr) begin
                m_dirty[idx][hw] = 1'b1;
            end
            return 1'b1;
        end
        if (!m_valid[idx][0]) begin
            v = 0;
        end else if (!m_valid[idx][1]) begin
            v = 1;
        end else begin
            v = m_mru[idx] ? 0 : 1;  // not most recently used
        end
        wb      = m_valid[idx][v] && m_dirty[idx][v];
        wb_addr = {m_tag[idx][v], a[6:4], 4'b0000};
        m_valid[idx][v] = 1'b1;
        m_dirty[idx][v] = wr;  // write allocate
        m_tag[idx][v]   = tag;
        m_mru[idx]      = (v == 1);
        return 1'b0;
    endfunction

    // memory answers each held strobe after 1 to 4 cycles
    always @(posedge clk) begin
        if (mem_ready) begin
            mem_ready <= 1'b0;
            mem_wait = 0;
        end else if (mem_r || mem_w) begin
            if (mem_wait + 1 >= mem_delay) begin
                mem_ready <= 1'b1;
                if (mem_w) begin
                    mem_lines[mem_addr] = mem_w_data;
                end else begin
                    mem_r_data <= mem_line(mem_addr);
                end
                mem_rng   = lcg(mem_rng);
                mem_delay = 1 + int'(mem_rng[17:16]);
            end else begin
                mem_wait = mem_wait + 1;
            end
        end
    end

    task automatic close_request();
        if (!is_write) begin
            assert (r_data == exp_data) else begin
                errors++;
                $display("Fail %0t: read returned %h, expected %h", $time, r_data, exp_data);
            end
        end
        n_done++;
        busy = 1'b0;
    endtask

    // compares DUT outputs against the reference while a request runs
    always @(negedge clk) begin
        if (busy) begin
            if (mem_w && !wb_seen) begin
                wb_seen      = 1'b1;
                last_wb_addr = mem_addr;
                assert (exp_wb && mem_addr == exp_wb_addr) else begin
                    errors++;
                    $display("Fail %0t: write-back to %h, expected %0d at %h",
                             $time, mem_addr, exp_wb, exp_wb_addr);
                end
                assert (mem_w_data == ref_line(mem_addr)) else begin
                    errors++;
                    $display("Fail %0t: write-back data %h wrong", $time, mem_w_data);
                end
            end
            if (mem_r && !fetch_seen) begin
                fetch_seen = 1'b1;
                assert (mem_addr == exp_line_addr && wb_seen == exp_wb) else begin
                    errors++;
                    $display("Fail %0t: fetch at %h, expected %h, write-back done %0d of %0d",
                             $time, mem_addr, exp_line_addr, wb_seen, exp_wb);
                end
            end
            if (in_lookup) begin
                in_lookup = 1'b0;
                last_hit  = !miss;
                assert (miss == !exp_hit) else begin
                    errors++;
                    $display("Fail %0t: miss is %0d, expected %0d", $time, miss, !exp_hit);
                end
                if (!miss) begin
                    assert (!mem_r && !mem_w) else begin
                        errors++;
                        $display("Fail %0t: memory strobe on a hit", $time);
                    end
                    close_request();
                end
            end else if (!miss) begin
                close_request();  // refill cycle
            end
        end
    end

    task automatic issue(input logic wr, input word_t a, input word_t d);
        @(posedge clk);
        r_req  <= !wr;
        w_req  <= wr;
        addr   <= a;
        w_data <= d;
        is_write      = wr;
        exp_line_addr = {a[31:4], 4'b0000};
        exp_hit       = predict_access(a, wr, exp_wb, exp_wb_addr);
        if (wr) begin
            shadow[a] = d;
        end else begin
            exp_data = ref_word(a);
        end
        @(posedge clk);
        r_req <= 1'b0;
        w_req <= 1'b0;
        wb_seen    = 1'b0;
        fetch_seen = 1'b0;
        in_lookup  = 1'b1;
        busy       = 1'b1;
        while (busy) begin
            @(posedge clk);
        end
    endtask

    task automatic check_hit(input logic want, input string what);
        assert (last_hit == want) else begin
            errors++;
            $display("Fail %0t: %s, hit is %0d, expected %0d", $time, what, last_hit, want);
        end
    endtask

    initial begin
        word_t ra;
        logic  rwr;
        rstn       = 1'b0;
        addr       = '0;
        r_req      = 1'b0;
        w_req      = 1'b0;
        w_data     = '0;
        mem_r_data = '0;
        mem_ready  = 1'b0;
        errors     = 0;
        n_done     = 0;
        busy       = 1'b0;
        in_lookup  = 1'b0;
        mem_wait   = 0;
        mem_rng    = lcg(SEED);
        mem_delay  = 1 + int'(mem_rng[17:16]);
        stim_rng   = SEED;
        for (int s = 0; s < 8; s++) begin
            m_mru[s] = 1'b0;
            for (int w = 0; w < 2; w++) begin
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
                m_tag[s][w]   = '0;
            end
        end
        repeat (3) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        assert (!miss && !mem_r && !mem_w) else begin
            errors++;
            $display("Fail %0t: miss or memory strobe high after reset", $time);
        end

        issue(1'b0, 32'h0000_0100, '0);
        check_hit(1'b0, "first read");
        issue(1'b0, 32'h0000_0100, '0);
        check_hit(1'b1, "repeated read");
        issue(1'b1, 32'h0000_0100, 32'hdead_beef);
        check_hit(1'b1, "write hit");
        issue(1'b0, 32'h0000_0100, '0);
        check_hit(1'b1, "read after write hit");
        issue(1'b1, 32'h0000_0204, 32'h1234_5678);
        check_hit(1'b0, "write miss");
        issue(1'b0, 32'h0000_0208, '0);
        check_hit(1'b1, "other word of allocated line");

        // three tags on set 2, second one dirty
        issue(1'b0, 32'h0000_0420, '0);
        issue(1'b1, 32'h0000_0824, 32'hcafe_f00d);
        issue(1'b0, 32'h0000_0420, '0);
        check_hit(1'b1, "first tag touched again");
        issue(1'b0, 32'h0000_0c20, '0);
        check_hit(1'b0, "third tag");
        assert (wb_seen && last_wb_addr == 32'h0000_0820) else begin
            errors++;
            $display("Fail %0t: second tag line was not written back", $time);
        end
        issue(1'b0, 32'h0000_0824, '0);
        check_hit(1'b0, "evicted line read again");

        for (int n = 0; n < RAND_REQS; n++) begin
            stim_rng = lcg(stim_rng);
            ra  = {20'h00001, 3'b000, stim_rng[25:24], 2'b00, stim_rng[26],
                   stim_rng[28:27], 2'b00};  // 4 tags over sets 0 and 1
            rwr = stim_rng[30];
            stim_rng = lcg(stim_rng);
            issue(rwr, ra, stim_rng);
        end

        @(posedge clk);
        $display("requests: %0d, errors: %0d", n_done, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (MAX_CYCLES) @(posedge clk);
        $display("timeout, the cache did not finish its requests within %0d cycles", MAX_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule
